// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := vred_tb
FILELIST   := verilog.f
FLAGS      := --timing --assert
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TB FAILED
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/vred_settings.svh ====
`ifndef VRED_SETTINGS_SVH
`define VRED_SETTINGS_SVH

// ------------------------------
// Reduction engine sizing
// ------------------------------

`define VRED_LANES   4    // Lanes folded per cycle
`define VRED_MAX_VL  16   // Elements in one vs2 register
`define VRED_WORD_W  32   // SEW fixed at 32

`endif

// ==== src/vred_data_pkg.sv ====
`include "vred_settings.svh"

package vred_data_pkg;

    typedef logic [`VRED_WORD_W-1:0] word_t;
    typedef word_t [`VRED_LANES-1:0] lane_group_t;   // One group per cycle

    // Captured whole on an accepted start
    typedef struct packed {
        vred_isa_pkg::vinstr_u                instr;
        logic [$clog2(`VRED_MAX_VL+1)-1:0]    vl;     // 0 to MAX_VL elements
        word_t                                seed;   // vs1[0]
        logic [`VRED_MAX_VL-1:0]              mask;   // v0
        word_t [`VRED_MAX_VL-1:0]             vs2;
    } red_req_t;

    // Decoded control, shared by sequencer and reduction unit
    typedef struct packed {
        vred_isa_pkg::redop_t op;
        logic                 is_unsigned;   // Only meaningful for min/max
        logic                 mask_en;
        logic                 illegal;
    } red_ctrl_t;

    typedef struct packed {
        word_t result;
        logic  illegal;
    } red_rsp_t;

endpackage

// ==== src/vred_decoder.sv ====
`timescale 1ns/1ps

module vred_decoder (
    input  vred_isa_pkg::vinstr_u   instr,
    output vred_data_pkg::red_ctrl_t ctrl
);

    import vred_isa_pkg::*;

    // ------------------------------
    // OPMVV reduction decode
    // ------------------------------
    always_comb begin
        ctrl.op          = RED_SUM;
        ctrl.is_unsigned = 1'b0;
        ctrl.mask_en     = ~instr.f.vm;     // vm=0 selects v0 masking
        ctrl.illegal     = 1'b1;            // Cleared only on a known reduction

        if (instr.f.opcode == OPC_OPV && instr.f.funct3 == F3_OPMVV) begin
            ctrl.illegal = 1'b0;
            case (instr.f.funct6)
                F6_VREDSUM:  ctrl.op = RED_SUM;
                F6_VREDAND:  ctrl.op = RED_AND;
                F6_VREDOR:   ctrl.op = RED_OR;
                F6_VREDXOR:  ctrl.op = RED_XOR;
                F6_VREDMINU: begin
                    ctrl.op          = RED_MIN;
                    ctrl.is_unsigned = 1'b1;
                end
                F6_VREDMIN:  ctrl.op = RED_MIN;
                F6_VREDMAXU: begin
                    ctrl.op          = RED_MAX;
                    ctrl.is_unsigned = 1'b1;
                end
                F6_VREDMAX:  ctrl.op = RED_MAX;
                default:     ctrl.illegal = 1'b1;   // Other OPMVV ops not handled here
            endcase
        end
    end

    // A legal word gives a real op and the raw view agrees it is an OPMVV reduction
    always_comb begin
        if (!ctrl.illegal) begin
            assert (ctrl.op inside {RED_SUM, RED_AND, RED_OR, RED_XOR, RED_MIN, RED_MAX}
                    && instr.raw[6:0] == OPC_OPV && instr.raw[14:12] == F3_OPMVV
                    && instr.raw[31:29] == 3'b000)
                else $error("decoder passed a word outside the OPMVV reductions");
        end
    end

endmodule

// ==== src/vred_isa_pkg.sv ====
package vred_isa_pkg;

    // ------------------------------
    // Fixed ISA encodings
    // ------------------------------
    localparam logic [6:0] OPC_OPV  = 7'b1010111;   // OP-V major opcode
    localparam logic [2:0] F3_OPMVV = 3'b010;       // Integer vector-vector, mask/red group

    // funct6 for single-width integer reductions
    localparam logic [5:0] F6_VREDSUM  = 6'b000000;
    localparam logic [5:0] F6_VREDAND  = 6'b000001;
    localparam logic [5:0] F6_VREDOR   = 6'b000010;
    localparam logic [5:0] F6_VREDXOR  = 6'b000011;
    localparam logic [5:0] F6_VREDMINU = 6'b000100;
    localparam logic [5:0] F6_VREDMIN  = 6'b000101;
    localparam logic [5:0] F6_VREDMAXU = 6'b000110;
    localparam logic [5:0] F6_VREDMAX  = 6'b000111;

    // Reduction kind, signedness is carried beside it
    typedef enum logic [2:0] {
        RED_SUM,
        RED_AND,
        RED_OR,
        RED_XOR,
        RED_MIN,
        RED_MAX
    } redop_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;       // 0 means masked by v0
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opmvv_fields_t;

    // Same 32-bit word, raw or split into OPMVV fields
    typedef union packed {
        logic [31:0]   raw;
        opmvv_fields_t f;
    } vinstr_u;

endpackage

// ==== src/vred_reduction_unit.sv ====
`timescale 1ns/1ps

`include "vred_settings.svh"

module vred_reduction_unit (
    input  vred_data_pkg::red_ctrl_t   ctrl,
    input  vred_data_pkg::lane_group_t lanes,
    input  logic [`VRED_LANES-1:0]     lane_en,
    input  vred_data_pkg::word_t       acc,
    output vred_data_pkg::word_t       acc_next
);

    import vred_isa_pkg::*;
    import vred_data_pkg::*;

    localparam int LANES = `VRED_LANES;
    localparam int W     = `VRED_WORD_W;

    word_t       pad;        // Identity of the current op
    lane_group_t lanes_m;    // Lanes after padding
    word_t [1:0] pair;       // First tree level
    word_t       tree;

    // One two-input step of the reduction
    function automatic word_t combine(
        input redop_t op,
        input logic   uns,
        input word_t  a,
        input word_t  b
    );
        word_t r;
        logic  a_lt_b;
        a_lt_b = uns ? (a < b) : ($signed(a) < $signed(b));
        case (op)
            RED_SUM: r = a + b;
            RED_AND: r = a & b;
            RED_OR:  r = a | b;
            RED_XOR: r = a ^ b;
            RED_MIN: r = a_lt_b ? a : b;
            RED_MAX: r = a_lt_b ? b : a;
            default: r = a;   // Keep left operand
        endcase
        return r;
    endfunction

    // ------------------------------
    // Identity pad
    // ------------------------------
    always_comb begin
        case (ctrl.op)
            RED_AND: pad = '1;
            RED_MIN: pad = ctrl.is_unsigned ? '1 : {1'b0, {(W-1){1'b1}}};   // Max value
            RED_MAX: pad = ctrl.is_unsigned ? '0 : {1'b1, {(W-1){1'b0}}};   // Min value
            default: pad = '0;                                              // Sum, or, xor
        endcase
    end

    // Disabled lanes drop out by taking the identity
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lanes_m[i] = lane_en[i] ? lanes[i] : pad;
        end
    end

    // ------------------------------
    // Pairwise tree, then fold into acc
    // ------------------------------
    always_comb begin
        pair[0]  = combine(ctrl.op, ctrl.is_unsigned, lanes_m[0], lanes_m[1]);
        pair[1]  = combine(ctrl.op, ctrl.is_unsigned, lanes_m[2], lanes_m[3]);
        tree     = combine(ctrl.op, ctrl.is_unsigned, pair[0], pair[1]);
        acc_next = combine(ctrl.op, ctrl.is_unsigned, acc, tree);
    end

endmodule

// ==== src/vred_sequencer.sv ====
`timescale 1ns/1ps

`include "vred_settings.svh"

module vred_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  vred_data_pkg::red_req_t    req,
    input  vred_data_pkg::red_ctrl_t   ctrl,
    input  vred_data_pkg::word_t       acc_next,
    output vred_isa_pkg::vinstr_u      instr,
    output vred_data_pkg::lane_group_t lanes,
    output logic [`VRED_LANES-1:0]     lane_en,
    output vred_data_pkg::word_t       acc,
    output logic                       busy,
    output logic                       done,
    output vred_data_pkg::red_rsp_t    rsp
);

    import vred_data_pkg::*;

    localparam int LANES  = `VRED_LANES;
    localparam int MAX_VL = `VRED_MAX_VL;
    localparam int IDX_W  = $clog2(MAX_VL);          // Element index
    localparam int VL_W   = $clog2(MAX_VL + 1);
    localparam int GRP_W  = $clog2(MAX_VL / LANES);  // Group counter
    localparam int LANE_W = $clog2(LANES);

    red_req_t         req_q;     // Held request
    logic             run_q;     // Groups still to fold
    logic             done_q;
    logic [GRP_W-1:0] grp_q;     // Group being folded
    word_t            acc_q;
    red_rsp_t         rsp_q;
    logic             accept;
    logic [VL_W-1:0]  next_base; // First element of the following group
    logic             last_grp;

    assign accept = start && !busy;

    // Port word is forwarded in the accept cycle, so an illegal word finishes at once
    assign instr.raw = accept ? req.instr.raw : req_q.instr.raw;

    assign next_base = VL_W'({grp_q, {LANE_W{1'b0}}}) + VL_W'(LANES);
    assign last_grp  = (next_base >= req_q.vl);   // vl of 0 still takes one group

    // ------------------------------
    // Lane select and enables
    // ------------------------------
    always_comb begin
        logic [IDX_W-1:0] elem;
        for (int i = 0; i < LANES; i++) begin
            elem       = {grp_q, LANE_W'(i)};
            lanes[i]   = req_q.vs2[elem];
            lane_en[i] = (VL_W'(elem) < req_q.vl) && (!ctrl.mask_en || req_q.mask[elem]);
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
            acc_q <= req.seed;           // Fold starts from vs1[0]
        end else if (run_q) begin
            acc_q <= acc_next;
        end
    end

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            grp_q  <= '0;
            rsp_q  <= '0;
        end else begin
            done_q <= 1'b0;                                    // Single-cycle pulse
            if (accept) begin
                grp_q <= '0;
                if (ctrl.illegal) begin
                    done_q <= 1'b1;                            // Skip the walk
                    rsp_q  <= '{result: req.seed, illegal: 1'b1};
                end else begin
                    run_q <= 1'b1;
                end
            end else if (run_q) begin
                grp_q <= grp_q + GRP_W'(1);
                if (last_grp) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                    rsp_q  <= '{result: acc_next, illegal: 1'b0};
                end
            end
        end
    end

    assign busy = run_q | done_q;   // Covers the done cycle too
    assign done = done_q;
    assign acc  = acc_q;
    assign rsp  = rsp_q;

    // Done is a strobe, never a level
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

    // A start that lands while busy must not restart the walk
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (start && busy) |=> grp_q == ($past(run_q) ? $past(grp_q) + GRP_W'(1) : $past(grp_q)));

endmodule

// ==== src/vred_top.sv ====
`timescale 1ns/1ps

`include "vred_settings.svh"

module vred_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  vred_data_pkg::red_req_t req,
    output logic                    busy,
    output logic                    done,
    output vred_data_pkg::red_rsp_t rsp
);

    import vred_isa_pkg::*;
    import vred_data_pkg::*;

    // ------------------------------
    // Internal wires
    // ------------------------------
    vinstr_u                 instr;      // Word under decode
    red_ctrl_t               ctrl;
    lane_group_t             lanes;
    logic [`VRED_LANES-1:0]  lane_en;
    word_t                   acc;
    word_t                   acc_next;   // Combinational fold result

    vred_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .req      (req),
        .ctrl     (ctrl),
        .acc_next (acc_next),
        .instr    (instr),
        .lanes    (lanes),
        .lane_en  (lane_en),
        .acc      (acc),
        .busy     (busy),
        .done     (done),
        .rsp      (rsp)
    );

    vred_decoder u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Cross-lane fold, one group per cycle
    vred_reduction_unit u_red (
        .ctrl     (ctrl),
        .lanes    (lanes),
        .lane_en  (lane_en),
        .acc      (acc),
        .acc_next (acc_next)
    );

endmodule

// ==== verif/vred_tb.sv ====
`timescale 1ns/1ps

`include "vred_settings.svh"

module vred_tb;

    import vred_isa_pkg::*;
    import vred_data_pkg::*;

    localparam int REC_W     = 22;   // Words per trace record
    localparam int MAX_CASES = 32;
    localparam int TIMEOUT   = 40;   // Cycles allowed for done
    localparam int LANES     = `VRED_LANES;
    localparam int MAX_VL    = `VRED_MAX_VL;

    logic        clk;
    logic        rst_n;
    logic        start;
    red_req_t    req;
    logic        busy;
    logic        done;
    red_rsp_t    rsp;
    logic [31:0] trace_mem [REC_W*MAX_CASES];
    int          error_count;
    int          pass_count;

    vred_top u_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .req   (req),
        .busy  (busy),
        .done  (done),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Start edge is cycle 0, done lands at G+1, or at 1 for an illegal word
    function automatic int expected_latency(input logic [31:0] vl, input logic illegal);
        int groups;
        groups = (int'(vl) + LANES - 1) / LANES;
        if (groups == 0) begin
            groups = 1;                    // vl of 0 still walks one group
        end
        return illegal ? 1 : groups + 1;
    endfunction

    // ------------------------------
    // Trace record to request
    // ------------------------------
    function automatic red_req_t load_request(input int base);
        red_req_t r;
        r.instr.raw = trace_mem[base];
        r.vl        = trace_mem[base+1][4:0];
        r.seed      = trace_mem[base+2];
        r.mask      = trace_mem[base+3][MAX_VL-1:0];
        for (int i = 0; i < MAX_VL; i++) begin
            r.vs2[i] = trace_mem[base+4+i];
        end
        return r;
    endfunction

    // Different request that must be dropped while busy
    function automatic red_req_t disturb_request(input red_req_t r);
        red_req_t d;
        d           = r;
        d.instr.raw = {F6_VREDSUM, 1'b1, 5'd8, 5'd4, F3_OPMVV, 5'd2, OPC_OPV};
        d.vl        = 5'd16;
        d.seed      = ~r.seed;
        d.mask      = ~r.mask;
        for (int i = 0; i < MAX_VL; i++) begin
            d.vs2[i] = ~r.vs2[i];
        end
        return d;
    endfunction

    // ------------------------------
    // One reduction case
    // ------------------------------
    task automatic run_case(input int idx);
        int          base;
        red_req_t    r;
        logic [31:0] exp_result;
        logic        exp_illegal;
        int          cycles;
        logic        seen;
        int          errors_before;
        base          = idx * REC_W;
        r             = load_request(base);
        exp_result    = trace_mem[base+20];
        exp_illegal   = trace_mem[base+21][0];
        errors_before = error_count;
        cycles        = 0;
        seen          = 1'b0;

        @(posedge clk);
        start <= 1'b1;                     // One-cycle start pulse
        req   <= r;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clk);
            if (cycles == 0) begin
                start <= 1'b1;             // Second start lands while busy
                req   <= disturb_request(r);
            end else begin
                start <= 1'b0;
            end
            cycles++;
            @(negedge clk);                // Outputs settled mid-cycle
            seen = done;
        end

        if (!seen) begin
            $display("Error: case %0d, done never arrived within %0d cycles", idx, TIMEOUT);
            error_count++;
        end else begin
            check_value("busy", 32'(busy), 32'd1);
            check_value("rsp.result", rsp.result, exp_result);
            check_value("rsp.illegal", 32'(rsp.illegal), 32'(exp_illegal));
            check_value("latency", cycles, expected_latency(trace_mem[base+1], exp_illegal));
        end

        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("done", 32'(done), 32'd0);            // Strobe, not a level
        check_value("rsp.result", rsp.result, exp_result); // Held after done

        if (error_count == errors_before) begin
            pass_count++;
            $display("case %0d ok: result %h illegal %0d in %0d cycles",
                     idx, rsp.result, rsp.illegal, cycles);
        end else begin
            $display("case %0d mismatch: %0d errors", idx, error_count - errors_before);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int n_cases;
        int errors_before;
        error_count = 0;
        pass_count  = 0;
        n_cases     = 0;
        rst_n       = 1'b0;
        start       = 1'b0;
        req         = '0;

        // Fill that no legal illegal-flag column can hold
        for (int a = 0; a < REC_W*MAX_CASES; a++) begin
            trace_mem[a] = {16'hA5A5, 16'(a)};
        end
        $readmemh("verif/vred_trace.txt", trace_mem);
        while (n_cases < MAX_CASES && trace_mem[n_cases*REC_W + 21] <= 32'd1) begin
            n_cases++;
        end

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        errors_before = error_count;
        check_value("busy", 32'(busy), 32'd0);            // Idle after reset
        check_value("done", 32'(done), 32'd0);
        check_value("rsp.result", rsp.result, 32'd0);
        check_value("rsp.illegal", 32'(rsp.illegal), 32'd0);
        if (error_count == errors_before) begin
            $display("reset ok");
        end else begin
            $display("reset mismatch: %0d errors", error_count - errors_before);
        end

        if (n_cases == 0) begin
            $display("Error: no cases could be read from the trace file");
            error_count++;
        end
        for (int k = 0; k < n_cases; k++) begin
            run_case(k);
        end

        $display("summary: %0d cases, %0d passed, %0d errors", n_cases, pass_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/vred_trace.txt ====
// instr vl seed mask vs2[0] .. vs2[15] expected_result expected_illegal
// All values hex, one reduction case per line
02822157 10 100 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 188 0
06822157 10 3c 0 ff fe fd ff ff ff ff ff 7f ff ff ff ff ff ff ff 3c 0
0a822157 10 1000 0 1 2 4 8 10 20 40 80 100 200 400 800 0 0 0 8000 9fff 0
0e822157 10 5 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 15 0
12822157 10 100 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 10 0
16822157 10 100 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 80000000 0
1a822157 10 100 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 ffffff00 0
1e822157 10 8 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 77 0
00822157 10 0 ff 1 2 3 4 5 6 7 8 9 a b c d e f 10 24 0
00822157 10 1000 aaaa 1 2 3 4 5 6 7 8 9 a b c d e f 10 1048 0
04822157 10 ffffffff fef9 ff fe fd ff ff ff ff ff 7f ff ff ff ff ff ff ff ff 0
10822157 10 ffffffff fffe 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 11 0
14822157 10 7fffffff fe7f 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 10 0
1c822157 10 80000000 100 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 ffffff00 0
18822157 10 1234 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 1234 0
02822157 6 0 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 15 0
02822157 0 77 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 77 0
1e822157 5 80000000 0 10 20 30 40 50 60 70 80000000 ffffff00 11 22 33 44 55 66 77 50 0
06822157 3 ffffffff 0 ff fe fd ff ff ff ff ff 7f ff ff ff ff ff ff ff fc 0
0c822157 d 5 ff0f 1 2 3 4 5 6 7 8 9 a b c d e f 10 8 0
02822133 10 1111 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 1111 1
02820157 10 2222 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 2222 1
22822157 10 3333 0 1 2 3 4 5 6 7 8 9 a b c d e f 10 3333 1

// ==== verilog.f ====
+incdir+include
src/vred_isa_pkg.sv
src/vred_data_pkg.sv
src/vred_decoder.sv
src/vred_reduction_unit.sv
src/vred_sequencer.sv
src/vred_top.sv
verif/vred_tb.sv
